// ==== mem_bus.f ====
+incdir+src
src/mem_bus_pkg.sv
src/ram_port_if.sv
src/address_decoder.sv
src/bus_arbiter.sv
src/work_ram.sv
src/flash_reader.sv
src/video_regs.sv
src/dma_fill.sv
src/mem_bus_top.sv
test/mem_bus_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := mem_bus_tb
FILELIST   := mem_bus.f
BUILD_DIR  := obj_dir
FLAGS      := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing -Wall --top-module $(TOP)
PASS_MSG   := all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== test/mem_bus_tb.sv ====
// Testbench for the memory bus top level.
// Drives CPU and DMA requests, models the external flash and checks
// every response against a scoreboard of RAM and video register contents.

`include "mem_bus_consts.svh"

module mem_bus_tb
    import mem_bus_pkg::*;
();

    localparam int CPU_TIMEOUT = 1000;
    localparam int FILL_BASE   = 'h300;
    localparam int FILL_WORDS  = 24;

    logic         clk;
    logic         rst;
    logic         cpu_valid;
    bus_addr_t    cpu_address;
    byte_strobe_t cpu_wstrb;
    bus_word_t    cpu_write_data;
    logic         cpu_ready;
    bus_word_t    cpu_read_data;
    logic         flash_req;
    ram_addr_t    flash_addr;
    logic         flash_ack;
    bus_word_t    flash_data;
    logic         dma_start;
    ram_addr_t    dma_base;
    dma_count_t   dma_count;
    bus_word_t    dma_fill;
    logic         dma_busy;

    logic [31:0]  lfsr;
    int           cycle;
    int           errors;
    int           tests_run;
    int           tests_bad;
    int           errors_at_start;
    int           flash_requests;
    string        test_name;
    bus_word_t    ram_model [int];
    video_word_t  video_model [4];

    mem_bus_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // bus protocol rules
    assert property (@(posedge clk) disable iff (rst) cpu_ready |=> !cpu_ready)
        else begin
            $display("cpu_ready was high in two consecutive cycles");
            errors++;
        end
    assert property (@(posedge clk) disable iff (rst) dma_busy |-> !cpu_ready)
        else begin
            $display("cpu_ready rose while the DMA was busy");
            errors++;
        end
    assert property (@(posedge clk) disable iff (rst)
            flash_req && !flash_ack |=> flash_req && $stable(flash_addr))
        else begin
            $display("flash request dropped or moved before its acknowledge");
            errors++;
        end
    assert property (@(posedge clk) disable iff (rst) flash_ack |=> cpu_ready)
        else begin
            $display("cpu_ready did not follow flash_ack by one cycle");
            errors++;
        end

    // one LFSR step per bit
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    // flash contents, known from the word address alone
    function automatic bus_word_t flash_word(ram_addr_t address);
        return {address ^ 12'h5a3, 8'hc3, address};
    endfunction

    function automatic bus_word_t merge_bytes(bus_word_t old, bus_word_t data,
                                              byte_strobe_t strobe);
        bus_word_t result;
        result = old;
        for (int i = 0; i < 4; i++) begin
            if (strobe[i]) begin
                result[8*i +: 8] = data[8*i +: 8];
            end
        end
        return result;
    endfunction

    function automatic bus_addr_t byte_address(bus_addr_t base, ram_addr_t word);
        return base | bus_addr_t'({word, 2'b00});
    endfunction

    task automatic compare(string what, logic [31:0] expected, logic [31:0] actual);
        assert (actual === expected)
            else begin
                $display("Fail %s %s: expected %h, actual %h", test_name, what,
                         expected, actual);
                errors++;
            end
    endtask

    task automatic begin_test(string name);
        test_name = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    // one CPU access; latency counts the cycles from valid to ready
    task automatic cpu_access(bus_addr_t address, byte_strobe_t wstrb, bus_word_t data,
                              output bus_word_t rdata, output int latency);
        @(posedge clk);
        cpu_valid      <= 1'b1;
        cpu_address    <= address;
        cpu_wstrb      <= wstrb;
        cpu_write_data <= data;
        latency = 0;
        @(negedge clk);
        while (!cpu_ready && latency < CPU_TIMEOUT) begin
            latency++;
            @(negedge clk);
        end
        if (!cpu_ready) begin
            $display("CPU access to %h never completed in %s", address, test_name);
            errors++;
        end
        rdata = cpu_read_data;
        @(posedge clk);
        cpu_valid <= 1'b0;
        cpu_wstrb <= '0;
    endtask

    // start a fill and follow it until busy falls, checking the status word
    task automatic run_fill(int base, int words, bus_word_t fill,
                            output int busy_cycles, output int done_cycle);
        @(posedge clk);
        dma_start <= 1'b1;
        dma_base  <= ram_addr_t'(base);
        dma_count <= dma_count_t'(words);
        dma_fill  <= fill;
        @(posedge clk);
        dma_start <= 1'b0;
        busy_cycles = 0;
        @(negedge clk);
        while (dma_busy && busy_cycles < words + 16) begin
            compare("status during fill",
                    {1'b1, 18'b0, dma_count_t'(words - busy_cycles)}, dut0.status_word);
            busy_cycles++;
            @(negedge clk);
        end
        if (dma_busy) begin
            $display("DMA fill never finished in %s", test_name);
            errors++;
        end
        done_cycle = cycle;
        for (int i = 0; i < words; i++) begin
            ram_model[base + i] = fill;
        end
    endtask

    // answers each request after 1 to 8 cycles
    initial begin : flash_model
        int delay;
        forever begin
            @(negedge clk);
            if (flash_req && !flash_ack) begin
                delay = 1 + int'(take_bits(3));
                repeat (delay) @(posedge clk);
                flash_ack  <= 1'b1;
                flash_data <= flash_word(flash_addr);
                flash_requests++;
                @(posedge clk);
                flash_ack <= 1'b0;
            end
        end
    end

    initial begin : main
        bus_word_t    got;
        bus_word_t    data;
        bus_word_t    fill;
        ram_addr_t    word;
        byte_strobe_t strobe;
        int           latency;
        int           busy_cycles;
        int           requests;
        int           read_done;
        int           fill_done;

        lfsr            = 32'hd996_0ef0;
        cycle           = 0;
        errors          = 0;
        tests_run       = 0;
        tests_bad       = 0;
        flash_requests  = 0;
        rst             = 1'b1;
        cpu_valid       = 1'b0;
        cpu_address     = '0;
        cpu_wstrb       = '0;
        cpu_write_data  = '0;
        flash_ack       = 1'b0;
        flash_data      = '0;
        dma_start       = 1'b0;
        dma_base        = '0;
        dma_count       = '0;
        dma_fill        = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        begin_test("ram");
        for (int i = 0; i < 8; i++) begin
            word = ram_addr_t'(take_bits(`RAM_ADDR_W));
            data = take_bits(32);
            cpu_access(byte_address(`RAM_BASE, word), 4'hf, data, got, latency);
            ram_model[int'(word)] = data;
            compare("write latency", 1, latency);
            strobe = byte_strobe_t'(take_bits(4));
            data = take_bits(32);
            cpu_access(byte_address(`RAM_BASE, word), strobe, data, got, latency);
            ram_model[int'(word)] = merge_bytes(ram_model[int'(word)], data, strobe);
            cpu_access(byte_address(`RAM_BASE, word), 4'h0, '0, got, latency);
            compare("read data", ram_model[int'(word)], got);
            compare("read latency", 1, latency);
        end
        end_test();

        begin_test("flash");
        for (int i = 0; i < 6; i++) begin
            word = ram_addr_t'(take_bits(`RAM_ADDR_W));
            requests = flash_requests;
            cpu_access(byte_address(`FLASH_BASE, word), 4'h0, '0, got, latency);
            compare("read data", flash_word(word), got);
            compare("requests", requests + 1, flash_requests);
        end
        requests = flash_requests;
        cpu_access(byte_address(`FLASH_BASE, 12'h010), 4'hf, 32'hdead_beef, got, latency);
        compare("write latency", 1, latency);
        compare("requests after write", requests, flash_requests);
        end_test();

        begin_test("video");
        cpu_access(byte_address(`VIDEO_BASE, 12'd2), 4'h0, '0, got, latency);
        compare("reset value", 0, got);
        for (int i = 0; i < 4; i++) begin
            video_model[i] = video_word_t'(take_bits(16));
            data = {video_word_t'(take_bits(16)), video_model[i]};
            cpu_access(byte_address(`VIDEO_BASE, ram_addr_t'(i)), 4'h3, data, got, latency);
            compare("write latency", 1, latency);
        end
        // upper lanes alone do not reach a register
        cpu_access(byte_address(`VIDEO_BASE, 12'd1), 4'hc, 32'hffff_ffff, got, latency);
        for (int i = 0; i < 4; i++) begin
            cpu_access(byte_address(`VIDEO_BASE, ram_addr_t'(i)), 4'h0, '0, got, latency);
            compare("read data", {2{video_model[i]}}, got);
            compare("read latency", 1, latency);
        end
        end_test();

        begin_test("dma");
        data = take_bits(32);
        cpu_access(byte_address(`RAM_BASE, ram_addr_t'(FILL_BASE - 1)), 4'hf, data, got,
                   latency);
        ram_model[FILL_BASE - 1] = data;
        data = take_bits(32);
        cpu_access(byte_address(`RAM_BASE, ram_addr_t'(FILL_BASE + FILL_WORDS)), 4'hf, data,
                   got, latency);
        ram_model[FILL_BASE + FILL_WORDS] = data;
        fill = take_bits(32);
        fork
            run_fill(FILL_BASE, FILL_WORDS, fill, busy_cycles, fill_done);
            begin
                @(posedge clk);
                cpu_access(byte_address(`RAM_BASE, ram_addr_t'(FILL_BASE + 5)), 4'h0, '0,
                           got, latency);
                read_done = cycle;
            end
        join
        compare("busy cycles", FILL_WORDS, busy_cycles);
        compare("stalled read", fill, got);
        assert (read_done > fill_done)
            else begin
                $display("CPU read in %s completed before the fill finished", test_name);
                errors++;
            end
        for (int i = FILL_BASE - 1; i <= FILL_BASE + FILL_WORDS; i++) begin
            cpu_access(byte_address(`RAM_BASE, ram_addr_t'(i)), 4'h0, '0, got, latency);
            compare("word around fill", ram_model[i], got);
        end
        end_test();

        begin_test("status");
        cpu_access(`STATUS_BASE, 4'h0, '0, got, latency);
        compare("idle status", 0, got);
        compare("status latency", 1, latency);
        fill = take_bits(32);
        run_fill('h800, 200, fill, busy_cycles, fill_done);
        compare("long fill busy cycles", 200, busy_cycles);
        cpu_access(`STATUS_BASE, 4'h0, '0, got, latency);
        compare("status after fill", 0, got);
        end_test();

        begin_test("unmapped");
        cpu_access(`VIDEO_BASE | 16'h0010, 4'h0, '0, got, latency);
        compare("video hole read", 0, got);
        compare("video hole latency", 1, latency);
        cpu_access(`STATUS_BASE | 16'h0004, 4'h0, '0, got, latency);
        compare("status hole read", 0, got);
        // would alias register 0 if the hole were decoded
        cpu_access(`VIDEO_BASE | 16'h0010, 4'hf, 32'h1234_5678, got, latency);
        compare("hole write latency", 1, latency);
        cpu_access(`VIDEO_BASE, 4'h0, '0, got, latency);
        compare("register 0 after hole write", {2{video_model[0]}}, got);
        end_test();

        $display("%0d tests run, %0d with errors, %0d errors in total", tests_run, tests_bad,
                 errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== src/mem_bus_top.sv ====
// Memory bus top level: CPU, flash and DMA ports in, all targets inside.
// The flash itself sits outside behind flash_req / flash_ack.

module mem_bus_top
    import mem_bus_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    input  logic         cpu_valid,
    input  bus_addr_t    cpu_address,
    input  byte_strobe_t cpu_wstrb,
    input  bus_word_t    cpu_write_data,
    output logic         cpu_ready,
    output bus_word_t    cpu_read_data,

    output logic         flash_req,
    output ram_addr_t    flash_addr,
    input  logic         flash_ack,
    input  bus_word_t    flash_data,

    input  logic         dma_start,
    input  ram_addr_t    dma_base,
    input  dma_count_t   dma_count,
    input  bus_word_t    dma_fill,
    output logic         dma_busy
);

    logic        ram_en;
    logic        flash_en;
    logic        video_en;
    logic        status_en;
    logic        flash_ready;
    bus_word_t   flash_read_data;
    logic        video_ready;
    video_word_t video_read_data;
    ram_addr_t   dma_address;
    bus_word_t   dma_write_data;
    dma_count_t  dma_remaining;
    bus_word_t   status_word;

    ram_port_if ram_port ();

    // busy flag on top, words left at the bottom
    assign status_word = {dma_busy, {(31 - $bits(dma_count_t)){1'b0}}, dma_remaining};

    // the CPU is stalled, so nothing is decoded while the DMA runs
    address_decoder decoder (
        .address   (cpu_address),
        .valid     (cpu_valid && !dma_busy),
        .ram_en    (ram_en),
        .flash_en  (flash_en),
        .video_en  (video_en),
        .status_en (status_en)
    );

    bus_arbiter arbiter (
        .clk             (clk),
        .rst             (rst),
        .cpu_valid       (cpu_valid),
        .cpu_address     (cpu_address),
        .cpu_wstrb       (cpu_wstrb),
        .cpu_write_data  (cpu_write_data),
        .dma_busy        (dma_busy),
        .dma_address     (dma_address),
        .dma_write_data  (dma_write_data),
        .ram_en          (ram_en),
        .flash_en        (flash_en),
        .video_en        (video_en),
        .status_en       (status_en),
        .flash_ready     (flash_ready),
        .flash_read_data (flash_read_data),
        .video_ready     (video_ready),
        .video_read_data (video_read_data),
        .status_word     (status_word),
        .cpu_ready       (cpu_ready),
        .cpu_read_data   (cpu_read_data),
        .ram             (ram_port.master)
    );

    work_ram ram (
        .clk  (clk),
        .port (ram_port.memory)
    );

    flash_reader flash (
        .clk        (clk),
        .rst        (rst),
        .flash_en   (flash_en),
        .address    (cpu_address),
        .write      (|cpu_wstrb),
        .ready      (flash_ready),
        .read_data  (flash_read_data),
        .flash_req  (flash_req),
        .flash_addr (flash_addr),
        .flash_ack  (flash_ack),
        .flash_data (flash_data)
    );

    video_regs video (
        .clk        (clk),
        .rst        (rst),
        .video_en   (video_en),
        .address    (cpu_address),
        .wstrb      (cpu_wstrb),
        .write_data (cpu_write_data),
        .ready      (video_ready),
        .read_data  (video_read_data)
    );

    dma_fill dma (
        .clk        (clk),
        .rst        (rst),
        .start      (dma_start),
        .base       (dma_base),
        .count      (dma_count),
        .fill       (dma_fill),
        .busy       (dma_busy),
        .address    (dma_address),
        .write_data (dma_write_data),
        .remaining  (dma_remaining)
    );

endmodule

// ==== src/dma_fill.sv ====
// DMA fill engine: writes one word value to a run of consecutive RAM words.
// One word per cycle; busy covers exactly the write cycles.

module dma_fill
    import mem_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  ram_addr_t  base,
    input  dma_count_t count,
    input  bus_word_t  fill,
    output logic       busy,
    output ram_addr_t  address,
    output bus_word_t  write_data,
    output dma_count_t remaining
);

    dma_state_t state;
    logic       launch;

    // zero-length fills and starts while running are ignored
    assign launch = (state == DMA_IDLE) && start && (count != '0);
    assign busy   = state == DMA_RUN;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= DMA_IDLE;
            remaining <= '0;
        end else begin
            case (state)
                DMA_IDLE: begin
                    if (launch) begin
                        state     <= DMA_RUN;
                        remaining <= count;
                    end
                end
                DMA_RUN: begin
                    remaining <= remaining - 1'b1;
                    if (remaining == dma_count_t'(1)) begin
                        state <= DMA_IDLE;
                    end
                end
                default: state <= DMA_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            address    <= base;
            write_data <= fill;
        end else if (busy) begin
            address <= address + 1'b1;
        end
    end

endmodule

// ==== src/video_regs.sv ====
// Four 16-bit video registers on the CPU bus.
// Answers once per selection and stays quiet for the following cycle.

module video_regs
    import mem_bus_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         video_en,
    input  bus_addr_t    address,
    input  byte_strobe_t wstrb,
    input  bus_word_t    write_data,
    output logic         ready,
    output video_word_t  read_data
);

    video_word_t regs [4];
    logic        answered;
    logic [1:0]  sel;

    assign sel   = address[3:2];
    assign ready = video_en && !answered;

    always_ff @(posedge clk) begin
        if (rst) begin
            answered <= 1'b0;
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else begin
            answered <= ready;
            // only the low halfword lanes carry register data
            if (ready && |wstrb[1:0]) begin
                regs[sel] <= write_data[15:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ready) begin
            read_data <= regs[sel];
        end
    end

endmodule

// ==== src/flash_reader.sv ====
// Bridges CPU flash reads to the external flash request/acknowledge port.
// Writes into the flash window are acknowledged and dropped.

`include "mem_bus_consts.svh"

module flash_reader
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      flash_en,
    input  bus_addr_t address,
    input  logic      write,
    output logic      ready,
    output bus_word_t read_data,
    output logic      flash_req,
    output ram_addr_t flash_addr,
    input  logic      flash_ack,
    input  bus_word_t flash_data
);

    // busy spans the request and the cycle after the ack
    logic      busy;
    logic      write_done;
    logic      issue;
    logic      write_ready;
    bus_addr_t offset;

    assign offset      = address - bus_addr_t'(`FLASH_BASE);
    assign issue       = flash_en && !write && !busy;
    assign write_ready = flash_en && write && !write_done;
    assign ready       = (flash_req && flash_ack) || write_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            flash_req  <= 1'b0;
            write_done <= 1'b0;
        end else begin
            write_done <= write_ready;
            if (issue) begin
                busy      <= 1'b1;
                flash_req <= 1'b1;
            end else if (flash_req && flash_ack) begin
                flash_req <= 1'b0;
            end else if (!flash_req) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            flash_addr <= offset[`RAM_ADDR_W+1:2];
        end
        if (flash_req && flash_ack) begin
            read_data <= flash_data;
        end
    end

endmodule

// ==== src/work_ram.sv ====
// Work RAM with per-byte write strobes and a registered read port.
// Reads in a write cycle return the old word.

`include "mem_bus_consts.svh"

module work_ram
    import mem_bus_pkg::*;
(
    input logic        clk,
    ram_port_if.memory port
);

    bus_word_t mem [`RAM_DEPTH];

    always_ff @(posedge clk) begin
        if (port.cs) begin
            for (int i = 0; i < $bits(byte_strobe_t); i++) begin
                if (port.wstrb[i]) begin
                    mem[port.address][8*i +: 8] <= port.write_data[8*i +: 8];
                end
            end
            port.read_data <= mem[port.address];
        end
    end

endmodule

// ==== src/bus_arbiter.sv ====
// Picks the RAM master, forms the CPU ready strobe and steers read data.
// The DMA takes the RAM port whenever it is busy; the CPU simply waits.

`include "mem_bus_consts.svh"

module bus_arbiter
    import mem_bus_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    input  logic         cpu_valid,
    input  bus_addr_t    cpu_address,
    input  byte_strobe_t cpu_wstrb,
    input  bus_word_t    cpu_write_data,

    input  logic         dma_busy,
    input  ram_addr_t    dma_address,
    input  bus_word_t    dma_write_data,

    input  logic         ram_en,
    input  logic         flash_en,
    input  logic         video_en,
    input  logic         status_en,

    input  logic         flash_ready,
    input  bus_word_t    flash_read_data,
    input  logic         video_ready,
    input  video_word_t  video_read_data,
    input  bus_word_t    status_word,

    output logic         cpu_ready,
    output bus_word_t    cpu_read_data,

    ram_port_if.master   ram
);

    logic unmapped;
    logic ready_q;
    logic flash_en_q;

    always_comb begin
        if (dma_busy) begin
            ram.address    = dma_address;
            ram.write_data = dma_write_data;
            ram.wstrb      = '1;
            ram.cs         = 1'b1;
        end else begin
            ram.address    = cpu_address[`RAM_ADDR_W+1:2];
            ram.write_data = cpu_write_data;
            ram.wstrb      = cpu_wstrb;
            ram.cs         = ram_en;
        end
    end

    assign unmapped = cpu_valid && !dma_busy
        && !(ram_en || flash_en || video_en || status_en);

    // single-cycle targets complete on the next edge
    always_ff @(posedge clk) begin
        if (rst || dma_busy) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= ((ram_en || status_en || unmapped) && !ready_q)
                || video_ready || flash_ready;
        end
    end

    // a strobe formed as the DMA starts is dropped and the access retried later
    assign cpu_ready = ready_q && !dma_busy;

    // flash data is latched, so its select lags by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            flash_en_q <= 1'b0;
        end else begin
            flash_en_q <= flash_en;
        end
    end

    always_comb begin
        if (flash_en_q) begin
            cpu_read_data = flash_read_data;
        end else if (video_en) begin
            cpu_read_data = {2{video_read_data}};
        end else if (status_en) begin
            cpu_read_data = status_word;
        end else if (unmapped) begin
            cpu_read_data = '0;
        end else begin
            cpu_read_data = ram.read_data;
        end
    end

endmodule

// ==== src/address_decoder.sv ====
// Decodes a CPU byte address into one-hot target enables.
// Video and status only occupy the bottom of their regions; the rest is unmapped.

`include "mem_bus_consts.svh"

module address_decoder
    import mem_bus_pkg::*;
(
    input  bus_addr_t address,
    input  logic      valid,
    output logic      ram_en,
    output logic      flash_en,
    output logic      video_en,
    output logic      status_en
);

    region_t region;
    logic    video_hit;
    logic    status_hit;

    assign region = region_t'(address[`BUS_ADDR_W-1 -: 2]);

    // four video registers, one status word
    assign video_hit  = address[`BUS_ADDR_W-3:4] == '0;
    assign status_hit = address[`BUS_ADDR_W-3:2] == '0;

    assign ram_en    = valid && (region == REGION_RAM);
    assign flash_en  = valid && (region == REGION_FLASH);
    assign video_en  = valid && (region == REGION_VIDEO) && video_hit;
    assign status_en = valid && (region == REGION_STATUS) && status_hit;

endmodule

// ==== src/ram_port_if.sv ====
// Single-port RAM bus between the arbiter and the work RAM.
// A cycle with cs high reads; a nonzero wstrb also writes those bytes.

interface ram_port_if
    import mem_bus_pkg::*;
();

    ram_addr_t    address;
    bus_word_t    write_data;
    byte_strobe_t wstrb;
    logic         cs;

    // registered, one cycle after cs
    bus_word_t    read_data;

    modport master (
        output address, write_data, wstrb, cs,
        input  read_data
    );

    modport memory (
        input  address, write_data, wstrb, cs,
        output read_data
    );

endinterface

// ==== src/mem_bus_pkg.sv ====
// Shared types for the memory bus.
// Modules pull these in with a wildcard import in their header.

`include "mem_bus_consts.svh"

package mem_bus_pkg;

    typedef logic [`BUS_ADDR_W-1:0] bus_addr_t;
    typedef logic [`RAM_ADDR_W-1:0] ram_addr_t;
    typedef logic [31:0] bus_word_t;
    typedef logic [3:0] byte_strobe_t;
    typedef logic [15:0] video_word_t;

    // one extra bit so a fill can cover the whole RAM
    typedef logic [`RAM_ADDR_W:0] dma_count_t;

    // region codes as they appear in the top address bits
    typedef enum logic [1:0] {
        REGION_RAM    = 2'(`RAM_BASE >> (`BUS_ADDR_W - 2)),
        REGION_FLASH  = 2'(`FLASH_BASE >> (`BUS_ADDR_W - 2)),
        REGION_VIDEO  = 2'(`VIDEO_BASE >> (`BUS_ADDR_W - 2)),
        REGION_STATUS = 2'(`STATUS_BASE >> (`BUS_ADDR_W - 2))
    } region_t;

    typedef enum logic {
        DMA_IDLE,
        DMA_RUN
    } dma_state_t;

endpackage

// ==== src/mem_bus_consts.svh ====
// Address map and sizing constants for the memory bus.
// Include this in any file that slices addresses or sizes memories.

`ifndef MEM_BUS_CONSTS_SVH
`define MEM_BUS_CONSTS_SVH

// CPU byte address width
`define BUS_ADDR_W 16

// work RAM is 4096 words of 32 bits
`define RAM_ADDR_W 12
`define RAM_DEPTH  (1 << `RAM_ADDR_W)

// the top two address bits select the region
`define RAM_BASE    16'h0000
`define FLASH_BASE  16'h4000
`define VIDEO_BASE  16'h8000
`define STATUS_BASE 16'hc000

`endif
